//--- include/loop_defines.svh
`ifndef LOOP_DEFINES_SVH
`define LOOP_DEFINES_SVH

// Datapath widths
`define LOOP_DATA_W         32
`define LOOP_EXT_W          16
`define LOOP_SHIFT_W        5
`define LOOP_GAIN_SEL_W     6

// Hard bound on the integrator accumulator magnitude
`define LOOP_INT_LIMIT      2000000000

// Shift used after reset and for gain selects above 15
`define LOOP_DEFAULT_SHIFT  5

`endif

//--- source/loop_pkg.sv
`default_nettype none

`include "loop_defines.svh"

package loop_pkg;

    typedef enum logic [3:0] {
        NORMAL    = 4'd0,
        CAL_DIFF  = 4'd1,   // Offset capture after a gain change
        SAT_POS   = 4'd2,
        SAT_NEG   = 4'd3,
        LIMIT_POS = 4'd4,
        LIMIT_NEG = 4'd5
    } loop_state_e;

    typedef struct packed {
        logic [`LOOP_GAIN_SEL_W-1:0]     gain_sel;
        logic [`LOOP_SHIFT_W-1:0]        p_shift;      // Proportional shift
        logic                            gain_mode;    // Bumpless gain change
        logic                            add_ext;
        logic                            zero;
        logic signed [`LOOP_DATA_W-1:0]  saturation;   // Symmetric clamp level
    } loop_ctrl_t;

    typedef struct packed {
        logic                            valid;
        logic signed [`LOOP_DATA_W-1:0]  data;
    } err_sample_t;

    typedef struct packed {
        logic                            valid;
        logic signed [`LOOP_DATA_W-1:0]  value;        // Clamped scaled integral
        logic signed [`LOOP_DATA_W-1:0]  err;          // Sample behind this value
    } int_result_t;

endpackage

`default_nettype wire

//--- source/gain_tracker.sv
`default_nettype none

`include "loop_defines.svh"

module gain_tracker (
    input  wire logic                        i_clk,
    input  wire logic                        i_rst_n,
    input  wire logic [`LOOP_GAIN_SEL_W-1:0] i_gain_sel,
    output logic                             o_gain_change,
    output logic [`LOOP_SHIFT_W-1:0]         o_shift_idx
);

    localparam int SEL_W    = `LOOP_GAIN_SEL_W;
    localparam int SHIFT_W  = `LOOP_SHIFT_W;
    localparam int MAX_SEL  = 15;

    localparam logic [SEL_W-1:0]   RST_SEL   = SEL_W'(`LOOP_DEFAULT_SHIFT);
    localparam logic [SHIFT_W-1:0] DEF_SHIFT = SHIFT_W'(`LOOP_DEFAULT_SHIFT);

    logic [SEL_W-1:0] gain_sel_q;   // Last seen gain select

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            gain_sel_q    <= RST_SEL;
            o_gain_change <= 1'b0;
            o_shift_idx   <= DEF_SHIFT;
        end else begin
            o_gain_change <= (i_gain_sel != gain_sel_q);
            gain_sel_q    <= i_gain_sel;
            // Map one cycle behind the registered copy
            if (gain_sel_q <= SEL_W'(MAX_SEL)) begin
                o_shift_idx <= gain_sel_q[SHIFT_W-1:0];
            end else begin
                o_shift_idx <= DEF_SHIFT;   // Out of range codes
            end
        end
    end

endmodule

`default_nettype wire

//--- source/integrator_core.sv
`default_nettype none

`include "loop_defines.svh"

module integrator_core
    import loop_pkg::*;
(
    input  wire logic                     i_clk,
    input  wire logic                     i_rst_n,
    input  wire err_sample_t              i_err,
    input  wire loop_ctrl_t               i_ctrl,
    input  wire logic                     i_gain_change,
    input  wire logic [`LOOP_SHIFT_W-1:0] i_shift_idx,
    output int_result_t                   o_result,
    output logic                          o_saturated
);

    localparam int DATA_W = `LOOP_DATA_W;
    localparam int WIDE_W = `LOOP_DATA_W + 2;   // Headroom for sums of two words

    localparam logic signed [WIDE_W-1:0] LIMIT_P = WIDE_W'(`LOOP_INT_LIMIT);
    localparam logic signed [WIDE_W-1:0] LIMIT_N = -LIMIT_P;

    loop_state_e               state_q;
    loop_state_e               state_d;

    logic signed [DATA_W-1:0]  acc_q;        // Integrator accumulator
    logic signed [DATA_W-1:0]  acc_used_q;   // Accumulator behind value_q
    logic signed [WIDE_W-1:0]  offset_q;     // Bumpless offset
    logic signed [DATA_W-1:0]  value_q;      // Clamped scaled integral

    logic                      stg1_valid_q;
    logic signed [DATA_W-1:0]  stg1_err_q;
    logic                      res_valid_q;
    logic signed [DATA_W-1:0]  res_err_q;

    logic signed [WIDE_W-1:0]  sat_p;
    logic signed [WIDE_W-1:0]  sat_n;
    logic signed [DATA_W-1:0]  acc_shift;
    logic signed [DATA_W-1:0]  used_shift;
    logic signed [WIDE_W-1:0]  offset_eff;
    logic signed [WIDE_W-1:0]  off_term;
    logic signed [WIDE_W-1:0]  raw;
    logic signed [WIDE_W-1:0]  sum;
    logic                      hold_pos;
    logic                      hold_neg;
    logic signed [DATA_W-1:0]  acc_next;
    logic signed [DATA_W-1:0]  value_next;

    assign sat_p      = WIDE_W'(i_ctrl.saturation);
    assign sat_n      = -sat_p;
    assign acc_shift  = acc_q >>> i_shift_idx;
    assign used_shift = acc_used_q >>> i_shift_idx;

    // In CAL_DIFF the new offset is already used by a result computed that cycle
    always_comb begin
        offset_eff = offset_q;
        if (state_q == CAL_DIFF) begin
            if (i_ctrl.gain_mode) begin
                offset_eff = WIDE_W'(value_q) - WIDE_W'(used_shift);
            end else begin
                offset_eff = WIDE_W'(0);
            end
        end
    end

    always_comb begin
        off_term = WIDE_W'(0);
        if (i_ctrl.gain_mode) begin
            off_term = offset_eff;
        end
    end

    assign raw = WIDE_W'(acc_shift) + off_term;   // Scaled integral before the clamp

    always_comb begin
        if (raw > sat_p) begin
            value_next = DATA_W'(sat_p);
        end else if (raw < sat_n) begin
            value_next = DATA_W'(sat_n);
        end else begin
            value_next = DATA_W'(raw);
        end
    end

    // No integration further into an active clamp
    assign hold_pos = (raw > sat_p) && (i_err.data > 0);
    assign hold_neg = (raw < sat_n) && (i_err.data < 0);

    assign sum = WIDE_W'(acc_q) + WIDE_W'(i_err.data);

    always_comb begin
        if (hold_pos || hold_neg) begin
            acc_next = acc_q;
        end else if (sum > LIMIT_P) begin
            acc_next = DATA_W'(LIMIT_P);   // Pin at the hard limit
        end else if (sum < LIMIT_N) begin
            acc_next = DATA_W'(LIMIT_N);
        end else begin
            acc_next = DATA_W'(sum);
        end
    end

    // State follows each result; a gain change takes priority
    always_comb begin
        state_d = state_q;
        if (i_gain_change) begin
            state_d = CAL_DIFF;
        end else if (stg1_valid_q) begin
            if (raw > sat_p) begin
                state_d = SAT_POS;
            end else if (raw < sat_n) begin
                state_d = SAT_NEG;
            end else if (WIDE_W'(acc_q) >= LIMIT_P) begin
                state_d = LIMIT_POS;
            end else if (WIDE_W'(acc_q) <= LIMIT_N) begin
                state_d = LIMIT_NEG;
            end else begin
                state_d = NORMAL;
            end
        end else if (state_q == CAL_DIFF) begin
            state_d = NORMAL;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q      <= NORMAL;
            acc_q        <= '0;
            acc_used_q   <= '0;
            offset_q     <= '0;
            value_q      <= '0;
            stg1_valid_q <= 1'b0;
            res_valid_q  <= 1'b0;
        end else if (i_ctrl.zero) begin
            state_q      <= NORMAL;   // Clear the loop and drop samples in flight
            acc_q        <= '0;
            acc_used_q   <= '0;
            offset_q     <= '0;
            value_q      <= '0;
            stg1_valid_q <= 1'b0;
            res_valid_q  <= 1'b0;
        end else begin
            state_q      <= state_d;
            stg1_valid_q <= i_err.valid;
            res_valid_q  <= stg1_valid_q;
            if (i_err.valid) begin
                acc_q <= acc_next;   // Stage 1
            end
            if (state_q == CAL_DIFF) begin
                offset_q <= offset_eff;
            end
            if (stg1_valid_q) begin
                value_q    <= value_next;   // Stage 2
                acc_used_q <= acc_q;
            end
        end
    end

    // Error travels alongside for the proportional path
    always_ff @(posedge i_clk) begin
        if (i_err.valid) begin
            stg1_err_q <= i_err.data;
        end
        if (stg1_valid_q) begin
            res_err_q <= stg1_err_q;
        end
    end

    assign o_result    = '{valid: res_valid_q, value: value_q, err: res_err_q};
    assign o_saturated = state_q inside {SAT_POS, SAT_NEG, LIMIT_POS, LIMIT_NEG};

endmodule

`default_nettype wire

//--- source/pi_output_stage.sv
`default_nettype none

`include "loop_defines.svh"

module pi_output_stage
    import loop_pkg::*;
(
    input  wire logic                          i_clk,
    input  wire logic                          i_rst_n,
    input  wire int_result_t                   i_result,
    input  wire loop_ctrl_t                    i_ctrl,
    input  wire logic signed [`LOOP_EXT_W-1:0] i_ext_sig,
    output logic signed [`LOOP_DATA_W-1:0]     o_out,
    output logic                               o_out_valid
);

    localparam int DATA_W = `LOOP_DATA_W;
    localparam int WIDE_W = `LOOP_DATA_W + 2;

    logic signed [WIDE_W-1:0] sat_p;
    logic signed [WIDE_W-1:0] sat_n;
    logic signed [DATA_W-1:0] err_shift;
    logic signed [WIDE_W-1:0] ext_term;
    logic signed [WIDE_W-1:0] sum;
    logic signed [DATA_W-1:0] sum_clamped;

    assign sat_p     = WIDE_W'(i_ctrl.saturation);
    assign sat_n     = -sat_p;
    assign err_shift = i_result.err >>> i_ctrl.p_shift;   // Proportional term

    always_comb begin
        ext_term = WIDE_W'(0);
        if (i_ctrl.add_ext) begin
            ext_term = WIDE_W'(i_ext_sig);   // Sign extended
        end
    end

    assign sum = WIDE_W'(i_result.value) + WIDE_W'(err_shift) + ext_term;

    always_comb begin
        if (sum > sat_p) begin
            sum_clamped = DATA_W'(sat_p);
        end else if (sum < sat_n) begin
            sum_clamped = DATA_W'(sat_n);
        end else begin
            sum_clamped = DATA_W'(sum);
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_out       <= '0;
            o_out_valid <= 1'b0;
        end else if (i_ctrl.zero) begin
            o_out       <= '0;
            o_out_valid <= 1'b0;
        end else begin
            o_out_valid <= i_result.valid;
            if (i_result.valid) begin
                o_out <= sum_clamped;   // Holds between strobes
            end
        end
    end

endmodule

`default_nettype wire

//--- source/pi_loop_filter.sv
`default_nettype none

`include "loop_defines.svh"

module pi_loop_filter
    import loop_pkg::*;
(
    input  wire logic                          i_clk,
    input  wire logic                          i_rst_n,
    input  wire err_sample_t                   i_err,
    input  wire loop_ctrl_t                    i_ctrl,
    input  wire logic signed [`LOOP_EXT_W-1:0] i_ext_sig,
    output logic signed [`LOOP_DATA_W-1:0]     o_out,
    output logic                               o_out_valid,
    output logic                               o_saturated
);

    logic                      gain_change;
    logic [`LOOP_SHIFT_W-1:0]  shift_idx;
    int_result_t               int_result;

    gain_tracker gain_tracker_inst (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_gain_sel    (i_ctrl.gain_sel),
        .o_gain_change (gain_change),
        .o_shift_idx   (shift_idx)
    );

    integrator_core integrator_core_inst (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_err         (i_err),
        .i_ctrl        (i_ctrl),
        .i_gain_change (gain_change),
        .i_shift_idx   (shift_idx),
        .o_result      (int_result),
        .o_saturated   (o_saturated)
    );

    pi_output_stage pi_output_stage_inst (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_result      (int_result),
        .i_ctrl        (i_ctrl),
        .i_ext_sig     (i_ext_sig),
        .o_out         (o_out),
        .o_out_valid   (o_out_valid)
    );

endmodule

`default_nettype wire

//--- tb/pi_loop_filter_assertions.sv
`default_nettype none

`include "loop_defines.svh"

module pi_loop_filter_assertions (
    input  wire logic                           i_clk,
    input  wire logic                           i_rst_n,
    input  wire logic                           i_res_valid,
    input  wire logic                           i_zero,
    input  wire logic                           i_out_valid,
    input  wire logic signed [`LOOP_DATA_W-1:0] i_out,
    input  wire logic signed [`LOOP_DATA_W-1:0] i_sat
);

    timeunit 1ns;
    timeprecision 1ns;

    strobe_follows: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_res_valid && !i_zero |=> i_out_valid)
        else $error("output strobe missing one cycle after a result strobe");

    strobe_source: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_out_valid |-> $past(i_res_valid))
        else $error("output strobe without a result strobe one cycle before");

    out_in_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_out_valid |-> (i_out <= i_sat) && (i_out >= -i_sat))
        else $error("output outside the saturation bounds");

    // Zero clears the core result and the output register together
    quiet_in_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_zero |=> !i_out_valid && !i_res_valid)
        else $error("strobe issued while zero is high");

endmodule

bind pi_output_stage pi_loop_filter_assertions assertions_inst (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_res_valid (i_result.valid),   // Result strobe of the integrator core
    .i_zero      (i_ctrl.zero),
    .i_out_valid (o_out_valid),
    .i_out       (o_out),
    .i_sat       (i_ctrl.saturation)
);

`default_nettype wire

//--- tb/pi_loop_filter_tb.sv
`default_nettype none

`include "loop_defines.svh"

module pi_loop_filter_tb
    import loop_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int     DATA_W     = `LOOP_DATA_W;
    localparam longint LIMIT      = `LOOP_INT_LIMIT;
    localparam int     N_INT      = 40;
    localparam int     N_SAT_UP   = 20;
    localparam int     N_SAT_DOWN = 30;
    localparam int     N_SAT_BACK = 20;
    localparam int     N_LIM_UP   = 6;
    localparam int     N_LIM_DOWN = 8;
    localparam int     N_GAIN     = 10;
    localparam int     N_EXT      = 15;
    localparam int     N_SAMPLES  = N_INT + N_SAT_UP + N_SAT_DOWN + N_SAT_BACK + N_LIM_UP
                                    + N_LIM_DOWN + 5 * N_GAIN + 1 + N_EXT + N_GAIN;
    localparam int     PHASES     = 20;   // Control changes, drains and zero pulses
    localparam int     GAP_CYCLES = 16;
    localparam int     STIM_CYCLES    = N_SAMPLES + PHASES * GAP_CYCLES;
    localparam int     TIMEOUT_CYCLES = 4 * STIM_CYCLES + 100;

    logic                          clk;
    logic                          rst_n;
    err_sample_t                   err_in;
    loop_ctrl_t                    ctrl_in;
    logic signed [`LOOP_EXT_W-1:0] ext_in;
    logic signed [DATA_W-1:0]      out;
    logic                          out_valid;
    logic                          saturated;

    integer                   seed;
    int                       cycle_cnt;
    int                       checked;
    string                    test_name;
    logic signed [DATA_W-1:0] exp_q[$];
    int                       stamp_q[$];   // Cycle in which each strobe was presented
    logic signed [DATA_W-1:0] exp_val;
    int                       stamp;

    longint                   ref_acc;
    longint                   ref_offset;
    longint                   ref_value;
    int                       ref_shift;

    pi_loop_filter pi_loop_filter_inst (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_err       (err_in),
        .i_ctrl      (ctrl_in),
        .i_ext_sig   (ext_in),
        .o_out       (out),
        .o_out_valid (out_valid),
        .o_saturated (saturated)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    function automatic longint clamp_to(input longint value, input longint bound);
        if (value > bound) begin
            return bound;
        end
        if (value < -bound) begin
            return -bound;
        end
        return value;
    endfunction

    function automatic int shift_for_sel(input logic [`LOOP_GAIN_SEL_W-1:0] sel);
        if (sel <= 15) begin
            return int'(sel);
        end
        return `LOOP_DEFAULT_SHIFT;
    endfunction

    // Steps the loop model by one sample and returns the expected output
    function automatic logic signed [DATA_W-1:0] expected_output(
        input logic signed [DATA_W-1:0] data
    );
        longint sat;
        longint off;
        longint raw;
        longint total;
        sat = longint'(ctrl_in.saturation);
        off = ctrl_in.gain_mode ? ref_offset : 64'sd0;
        raw = (ref_acc >>> ref_shift) + off;
        if (!((raw > sat && data > 0) || (raw < -sat && data < 0))) begin
            ref_acc = clamp_to(ref_acc + longint'(data), LIMIT);   // Frozen deeper in a clamp
        end
        raw = (ref_acc >>> ref_shift) + off;
        ref_value = clamp_to(raw, sat);
        total = ref_value + (longint'(data) >>> ctrl_in.p_shift);
        if (ctrl_in.add_ext) begin
            total = total + longint'(ext_in);
        end
        return DATA_W'(clamp_to(total, sat));
    endfunction

    task automatic check_value(input string name, input logic signed [63:0] expected,
                               input logic signed [63:0] actual);
        if (expected !== actual) begin
            $display("error: %s expected %0d actual %0d", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "check %s failed", name);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("output strobe in %s with no sample pending", test_name);
                $display("Simulation failed");
                $fatal(1, "unexpected output strobe");
            end else begin
                exp_val = exp_q.pop_front();
                stamp = stamp_q.pop_front();
                check_value({test_name, " output"}, exp_val, out);
                check_value({test_name, " latency"}, stamp + 3, cycle_cnt);
                checked = checked + 1;
            end
        end
    end

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            err_in <= '0;
        end
    endtask

    task automatic send_sample(input logic signed [DATA_W-1:0] data);
        @(posedge clk);
        exp_q.push_back(expected_output(data));
        stamp_q.push_back(cycle_cnt + 1);
        err_in <= '{valid: 1'b1, data: data};
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            err_in <= '0;
        end
        idle(2);
    endtask

    task automatic apply_ctrl(input loop_ctrl_t next);
        int new_shift;
        drain();
        new_shift = shift_for_sel(next.gain_sel);
        if (next.gain_sel != ctrl_in.gain_sel) begin
            if (next.gain_mode) begin
                ref_offset = ref_value - (ref_acc >>> new_shift);   // Keeps the integral value
            end else begin
                ref_offset = 0;
            end
        end
        ref_shift = new_shift;
        @(posedge clk);
        ctrl_in <= next;
        idle(6);
    endtask

    task automatic check_saturated(input logic expected);
        drain();
        @(negedge clk);
        check_value({test_name, " saturated flag"}, expected, saturated);
    endtask

    task automatic pulse_zero();
        loop_ctrl_t held;
        drain();
        held = ctrl_in;
        held.zero = 1'b1;
        @(posedge clk);
        ctrl_in <= held;
        repeat (2) begin
            @(posedge clk);
            err_in <= '{valid: 1'b1, data: 32'sd777777};   // Must be dropped
        end
        held.zero = 1'b0;
        @(posedge clk);
        ctrl_in <= held;
        err_in <= '0;
        idle(4);
        ref_acc = 0;
        ref_offset = 0;
        ref_value = 0;
        @(negedge clk);
        check_value({test_name, " zero output"}, 0, out);
        check_value({test_name, " zero flag"}, 0, saturated);
    endtask

    task automatic integrate_random();
        test_name = "integration";
        repeat (N_INT) send_sample($random(seed) % 100000);
        drain();
    endtask

    task automatic saturate_both_ways();
        loop_ctrl_t c;
        test_name = "saturation";
        c = ctrl_in;
        c.saturation = 32'sd100000;
        apply_ctrl(c);
        repeat (N_SAT_UP) send_sample(32'sd500000);
        check_saturated(1'b1);
        repeat (N_SAT_DOWN) send_sample(-32'sd500000);
        check_saturated(1'b1);
        repeat (N_SAT_BACK) send_sample(32'sd200000);   // Pulls the loop out of the clamp
        check_saturated(1'b0);
    endtask

    task automatic pin_at_limit();
        loop_ctrl_t c;
        test_name = "limit";
        c = ctrl_in;
        c.saturation = 32'sh7fffffff;
        c.gain_sel = 6'd2;
        c.p_shift = 5'd8;
        apply_ctrl(c);
        repeat (N_LIM_UP) send_sample(32'sd1500000000);
        check_saturated(1'b1);
        repeat (N_LIM_DOWN) send_sample(-32'sd1500000000);
        check_saturated(1'b1);
    endtask

    task automatic change_gain();
        loop_ctrl_t c;
        test_name = "gain";
        pulse_zero();
        c = ctrl_in;
        c.saturation = 32'sd1000000000;
        c.p_shift = 5'd4;
        c.gain_mode = 1'b1;
        c.gain_sel = 6'd3;
        apply_ctrl(c);
        repeat (2 * N_GAIN) send_sample($random(seed) % 100000);
        c.gain_sel = 6'd7;
        apply_ctrl(c);
        send_sample(32'sd0);   // Output equals the last integral value
        repeat (N_GAIN) send_sample($random(seed) % 100000);
        c.gain_sel = 6'd40;
        apply_ctrl(c);
        repeat (N_GAIN) send_sample($random(seed) % 100000);
        c.gain_mode = 1'b0;
        c.gain_sel = 6'd9;
        apply_ctrl(c);
        repeat (N_GAIN) send_sample($random(seed) % 100000);
        drain();
    endtask

    task automatic zero_and_ext();
        loop_ctrl_t c;
        test_name = "zero";
        pulse_zero();
        test_name = "external";
        @(posedge clk);
        ext_in <= -16'sd30000;
        c = ctrl_in;
        c.add_ext = 1'b1;
        apply_ctrl(c);
        repeat (N_EXT) send_sample($random(seed) % 100000);
        c.saturation = 32'sd25000;   // Clamp after the external term
        apply_ctrl(c);
        repeat (N_GAIN) send_sample($random(seed) % 100000);
        drain();
    endtask

    initial begin
        seed = 32'hf834f53c;
        clk = 1'b0;
        rst_n = 1'b0;
        err_in = '0;
        ext_in = '0;
        ctrl_in = '{gain_sel: 6'd5, p_shift: 5'd4, gain_mode: 1'b0, add_ext: 1'b0,
                    zero: 1'b0, saturation: 32'sd1000000000};
        cycle_cnt = 0;
        checked = 0;
        ref_acc = 0;
        ref_offset = 0;
        ref_value = 0;
        ref_shift = `LOOP_DEFAULT_SHIFT;
        test_name = "reset";
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        idle(2);
        integrate_random();
        saturate_both_ways();
        pin_at_limit();
        change_gain();
        zero_and_ext();
        if (checked != N_SAMPLES || exp_q.size() != 0) begin
            $display("only %0d of %0d outputs were checked", checked, N_SAMPLES);
            $display("Simulation failed");
            $fatal(1, "missing outputs");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
source/loop_pkg.sv
source/gain_tracker.sv
source/integrator_core.sv
source/pi_output_stage.sv
source/pi_loop_filter.sv
tb/pi_loop_filter_assertions.sv
tb/pi_loop_filter_tb.sv
